//--- hw/hyper_pkg.sv
// Fixed sizes for a two-chip, 16-word model; len holds beats minus one, 4 beats at most
package hyper_pkg;

    localparam int unsigned DATA_W         = 16;
    localparam int unsigned STRB_W         = 2;
    localparam int unsigned NUM_CHIPS      = 2;
    localparam int unsigned CHIP_WORDS     = 16;
    localparam int unsigned ADDR_W         = 5;
    localparam int unsigned LEN_W          = 2;
    localparam int unsigned FIFO_LOG_DEPTH = 2;

    // Transaction descriptor
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic              cs;
    } hyper_tf_t;

    // Write beat, strb masks bytes of data
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
        logic [STRB_W-1:0] strb;
    } hyper_tx_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
        logic              error;
    } hyper_rx_t;

endpackage

//--- hw/hyper_stream_fifo.sv
// Single-clock valid/ready FIFO of 2**FIFO_LOG_DEPTH entries; no bypass, output lags push by one cycle
`timescale 1ns/1ps

module hyper_stream_fifo #(
    parameter type T = logic
) (
    input  logic clk_phy_i,
    input  logic rst_i,
    input  T     data_i,
    input  logic valid_i,
    output logic ready_o,
    output T     data_o,
    output logic valid_o,
    input  logic ready_i
);
    import hyper_pkg::*;

    T                        mem_q [2**FIFO_LOG_DEPTH];
    logic [FIFO_LOG_DEPTH-1:0] wr_ptr_q;
    logic [FIFO_LOG_DEPTH-1:0] rd_ptr_q;
    logic [FIFO_LOG_DEPTH:0]   count_q;
    logic                      push;
    logic                      pop;

    // Full when the count reaches the depth
    assign ready_o = ~count_q[FIFO_LOG_DEPTH];
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    assign push = valid_i & ready_o;
    assign pop  = valid_o & ready_i;

    always_ff @(posedge clk_phy_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_phy_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

//--- hw/hyper_phy_arbiter.sv
// Round-robin PHY arbiter for AXI and uDMA; one descriptor per grant, TX beats only after it
`timescale 1ns/1ps

module hyper_phy_arbiter (
    input  logic                 clk_phy_i,
    input  logic                 rst_i,
    input  hyper_pkg::hyper_tf_t axi_trans_i,
    input  logic                 axi_trans_valid_i,
    output logic                 axi_trans_ready_o,
    input  hyper_pkg::hyper_tx_t axi_tx_i,
    input  logic                 axi_tx_valid_i,
    output logic                 axi_tx_ready_o,
    output hyper_pkg::hyper_rx_t axi_rx_o,
    output logic                 axi_rx_valid_o,
    input  logic                 axi_rx_ready_i,
    output logic                 axi_b_error_o,
    output logic                 axi_b_valid_o,
    input  logic                 axi_b_ready_i,
    input  hyper_pkg::hyper_tf_t udma_trans_i,
    input  logic                 udma_trans_valid_i,
    output logic                 udma_trans_ready_o,
    input  hyper_pkg::hyper_tx_t udma_tx_i,
    input  logic                 udma_tx_valid_i,
    output logic                 udma_tx_ready_o,
    output hyper_pkg::hyper_rx_t udma_rx_o,
    output logic                 udma_rx_valid_o,
    input  logic                 udma_rx_ready_i,
    output hyper_pkg::hyper_tf_t phy_trans_o,
    output logic                 phy_trans_valid_o,
    input  logic                 phy_trans_ready_i,
    output hyper_pkg::hyper_tx_t phy_tx_o,
    output logic                 phy_tx_valid_o,
    input  logic                 phy_tx_ready_i,
    input  hyper_pkg::hyper_rx_t phy_rx_i,
    input  logic                 phy_rx_valid_i,
    output logic                 phy_rx_ready_o,
    input  logic                 b_error_i,
    input  logic                 b_valid_i,
    output logic                 b_ready_o
);

    // sel_q and last_win_q: 0 is AXI, 1 is uDMA
    logic busy_q;
    logic sel_q;
    logic last_win_q;
    logic is_write_q;
    logic trans_sent_q;
    logic tx_done_q;
    logic winner;
    logic grant;
    logic trans_open;
    logic tx_open;
    logic trans_hs;
    logic tx_last_hs;
    logic rx_last_hs;
    logic b_hs;
    logic done;

    // Tie goes to whoever did not win last
    always_comb begin
        if (axi_trans_valid_i && udma_trans_valid_i) begin
            winner = ~last_win_q;
        end else begin
            winner = udma_trans_valid_i;
        end
    end

    assign grant      = ~busy_q & (axi_trans_valid_i | udma_trans_valid_i);
    assign trans_open = busy_q & ~trans_sent_q;
    assign tx_open    = busy_q & trans_sent_q & is_write_q & ~tx_done_q;

    assign phy_trans_o        = sel_q ? udma_trans_i : axi_trans_i;
    assign phy_trans_valid_o  = trans_open & (sel_q ? udma_trans_valid_i : axi_trans_valid_i);
    assign axi_trans_ready_o  = trans_open & ~sel_q & phy_trans_ready_i;
    assign udma_trans_ready_o = trans_open & sel_q & phy_trans_ready_i;

    assign phy_tx_o        = sel_q ? udma_tx_i : axi_tx_i;
    assign phy_tx_valid_o  = tx_open & (sel_q ? udma_tx_valid_i : axi_tx_valid_i);
    assign axi_tx_ready_o  = tx_open & ~sel_q & phy_tx_ready_i;
    assign udma_tx_ready_o = tx_open & sel_q & phy_tx_ready_i;

    assign axi_rx_o        = phy_rx_i;
    assign udma_rx_o       = phy_rx_i;
    assign axi_rx_valid_o  = busy_q & ~sel_q & phy_rx_valid_i;
    assign udma_rx_valid_o = busy_q & sel_q & phy_rx_valid_i;
    assign phy_rx_ready_o  = busy_q & (sel_q ? udma_rx_ready_i : axi_rx_ready_i);

    // uDMA write responses are swallowed here
    assign axi_b_error_o = b_error_i;
    assign axi_b_valid_o = busy_q & ~sel_q & b_valid_i;
    assign b_ready_o     = busy_q & (sel_q | axi_b_ready_i);

    assign trans_hs   = phy_trans_valid_o & phy_trans_ready_i;
    assign tx_last_hs = phy_tx_valid_o & phy_tx_ready_i & phy_tx_o.last;
    assign rx_last_hs = phy_rx_valid_i & phy_rx_ready_o & phy_rx_i.last;
    assign b_hs       = b_valid_i & b_ready_o;
    assign done       = trans_sent_q & (is_write_q ? b_hs : rx_last_hs);

    always_ff @(posedge clk_phy_i) begin
        if (rst_i) begin
            busy_q       <= 1'b0;
            sel_q        <= 1'b0;
            last_win_q   <= 1'b1;
            is_write_q   <= 1'b0;
            trans_sent_q <= 1'b0;
            tx_done_q    <= 1'b0;
        end else begin
            if (grant) begin
                busy_q       <= 1'b1;
                sel_q        <= winner;
                last_win_q   <= winner;
                trans_sent_q <= 1'b0;
                tx_done_q    <= 1'b0;
            end else if (done) begin
                busy_q <= 1'b0;
            end
            if (trans_hs) begin
                trans_sent_q <= 1'b1;
                is_write_q   <= phy_trans_o.write;
            end
            if (tx_last_hs) begin
                tx_done_q <= 1'b1;
            end
        end
    end

endmodule

//--- hw/hyper_mem_backend.sv
// Memory model in place of the PHY; beat count comes from len, the TX last flag is not checked
`timescale 1ns/1ps

module hyper_mem_backend (
    input  logic                 clk_phy_i,
    input  logic                 rst_i,
    input  hyper_pkg::hyper_tf_t trans_i,
    input  logic                 trans_valid_i,
    output logic                 trans_ready_o,
    input  hyper_pkg::hyper_tx_t tx_i,
    input  logic                 tx_valid_i,
    output logic                 tx_ready_o,
    output hyper_pkg::hyper_rx_t rx_o,
    output logic                 rx_valid_o,
    input  logic                 rx_ready_i,
    output logic                 b_error_o,
    output logic                 b_valid_o,
    input  logic                 b_ready_i
);
    import hyper_pkg::*;

    logic [DATA_W-1:0] mem_q [NUM_CHIPS][CHIP_WORDS];
    hyper_tf_t         desc_q;
    logic              active_q;
    logic [LEN_W-1:0]  cnt_q;
    logic              err_q;
    logic              b_valid_q;
    logic              b_error_q;
    hyper_rx_t         rx_q;
    logic              rx_valid_q;
    logic [ADDR_W:0]   beat_addr;
    logic [ADDR_W-2:0] word_idx;
    logic              oor;
    logic              last_beat;
    logic              trans_hs;
    logic              wr_beat;
    logic              rd_beat;

    // One extra bit so start plus count does not wrap
    assign beat_addr = {1'b0, desc_q.addr} + (ADDR_W + 1)'(cnt_q);
    assign word_idx  = beat_addr[ADDR_W-2:0];
    assign oor       = (beat_addr >= CHIP_WORDS);
    assign last_beat = (cnt_q == desc_q.len);

    assign trans_ready_o = ~active_q & ~b_valid_q;
    assign tx_ready_o    = active_q & desc_q.write;
    assign trans_hs      = trans_valid_i & trans_ready_o;
    assign wr_beat       = tx_valid_i & tx_ready_o;
    // Next read beat only when the output slot frees up
    assign rd_beat       = active_q & ~desc_q.write & (~rx_valid_q | rx_ready_i);

    assign rx_o       = rx_q;
    assign rx_valid_o = rx_valid_q;
    assign b_error_o  = b_error_q;
    assign b_valid_o  = b_valid_q;

    always_ff @(posedge clk_phy_i) begin
        if (rst_i) begin
            active_q   <= 1'b0;
            b_valid_q  <= 1'b0;
            rx_valid_q <= 1'b0;
        end else begin
            if (trans_hs) begin
                active_q <= 1'b1;
            end else if ((wr_beat || rd_beat) && last_beat) begin
                active_q <= 1'b0;
            end
            if (wr_beat && last_beat) begin
                b_valid_q <= 1'b1;
            end else if (b_ready_i) begin
                b_valid_q <= 1'b0;
            end
            if (rd_beat) begin
                rx_valid_q <= 1'b1;
            end else if (rx_ready_i) begin
                rx_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_phy_i) begin
        if (trans_hs) begin
            desc_q <= trans_i;
            cnt_q  <= '0;
            err_q  <= 1'b0;
        end else if (wr_beat || rd_beat) begin
            cnt_q <= cnt_q + 1'b1;
        end
        if (wr_beat) begin
            err_q <= err_q | oor;
        end
        if (wr_beat && last_beat) begin
            b_error_q <= err_q | oor;
        end
        if (rd_beat) begin
            rx_q.data  <= oor ? '0 : mem_q[desc_q.cs][word_idx];
            rx_q.last  <= last_beat;
            rx_q.error <= oor;
        end
    end

    // Out-of-range beats write nothing
    always_ff @(posedge clk_phy_i) begin
        if (rst_i) begin
            for (int c = 0; c < NUM_CHIPS; c++) begin
                for (int w = 0; w < CHIP_WORDS; w++) begin
                    mem_q[c][w] <= '0;
                end
            end
        end else if (wr_beat && !oor) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (tx_i.strb[b]) begin
                    mem_q[desc_q.cs][word_idx][8*b +: 8] <= tx_i.data[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- hw/hyper_arb_top.sv
// Arbiter, stream FIFOs and memory model on one clock; uDMA writes complete without a response
`timescale 1ns/1ps

module hyper_arb_top (
    input  logic                 clk_phy_i,
    input  logic                 rst_i,
    input  hyper_pkg::hyper_tf_t axi_trans_i,
    input  logic                 axi_trans_valid_i,
    output logic                 axi_trans_ready_o,
    input  hyper_pkg::hyper_tx_t axi_tx_i,
    input  logic                 axi_tx_valid_i,
    output logic                 axi_tx_ready_o,
    output hyper_pkg::hyper_rx_t axi_rx_o,
    output logic                 axi_rx_valid_o,
    input  logic                 axi_rx_ready_i,
    output logic                 axi_b_error_o,
    output logic                 axi_b_valid_o,
    input  logic                 axi_b_ready_i,
    input  hyper_pkg::hyper_tf_t udma_trans_i,
    input  logic                 udma_trans_valid_i,
    output logic                 udma_trans_ready_o,
    input  hyper_pkg::hyper_tx_t udma_tx_i,
    input  logic                 udma_tx_valid_i,
    output logic                 udma_tx_ready_o,
    output hyper_pkg::hyper_rx_t udma_rx_o,
    output logic                 udma_rx_valid_o,
    input  logic                 udma_rx_ready_i
);
    import hyper_pkg::*;

    // Arbiter side of the FIFOs
    hyper_tf_t phy_trans;
    logic      phy_trans_valid;
    logic      phy_trans_ready;
    hyper_tx_t phy_tx;
    logic      phy_tx_valid;
    logic      phy_tx_ready;
    hyper_rx_t phy_rx;
    logic      phy_rx_valid;
    logic      phy_rx_ready;

    // Back end side
    hyper_tf_t be_trans;
    logic      be_trans_valid;
    logic      be_trans_ready;
    hyper_tx_t be_tx;
    logic      be_tx_valid;
    logic      be_tx_ready;
    hyper_rx_t be_rx;
    logic      be_rx_valid;
    logic      be_rx_ready;
    logic      b_error;
    logic      b_valid;
    logic      b_ready;

    hyper_phy_arbiter u_arbiter (
        .phy_trans_o       ( phy_trans       ),
        .phy_trans_valid_o ( phy_trans_valid ),
        .phy_trans_ready_i ( phy_trans_ready ),
        .phy_tx_o          ( phy_tx          ),
        .phy_tx_valid_o    ( phy_tx_valid    ),
        .phy_tx_ready_i    ( phy_tx_ready    ),
        .phy_rx_i          ( phy_rx          ),
        .phy_rx_valid_i    ( phy_rx_valid    ),
        .phy_rx_ready_o    ( phy_rx_ready    ),
        .b_error_i         ( b_error         ),
        .b_valid_i         ( b_valid         ),
        .b_ready_o         ( b_ready         ),
        .*
    );

    hyper_stream_fifo #(
        .T ( hyper_tf_t )
    ) u_trans_fifo (
        .clk_phy_i ( clk_phy_i       ),
        .rst_i     ( rst_i           ),
        .data_i    ( phy_trans       ),
        .valid_i   ( phy_trans_valid ),
        .ready_o   ( phy_trans_ready ),
        .data_o    ( be_trans        ),
        .valid_o   ( be_trans_valid  ),
        .ready_i   ( be_trans_ready  )
    );

    hyper_stream_fifo #(
        .T ( hyper_tx_t )
    ) u_tx_fifo (
        .clk_phy_i ( clk_phy_i    ),
        .rst_i     ( rst_i        ),
        .data_i    ( phy_tx       ),
        .valid_i   ( phy_tx_valid ),
        .ready_o   ( phy_tx_ready ),
        .data_o    ( be_tx        ),
        .valid_o   ( be_tx_valid  ),
        .ready_i   ( be_tx_ready  )
    );

    // Read data flows back toward the arbiter
    hyper_stream_fifo #(
        .T ( hyper_rx_t )
    ) u_rx_fifo (
        .clk_phy_i ( clk_phy_i    ),
        .rst_i     ( rst_i        ),
        .data_i    ( be_rx        ),
        .valid_i   ( be_rx_valid  ),
        .ready_o   ( be_rx_ready  ),
        .data_o    ( phy_rx       ),
        .valid_o   ( phy_rx_valid ),
        .ready_i   ( phy_rx_ready )
    );

    hyper_mem_backend u_backend (
        .clk_phy_i     ( clk_phy_i      ),
        .rst_i         ( rst_i          ),
        .trans_i       ( be_trans       ),
        .trans_valid_i ( be_trans_valid ),
        .trans_ready_o ( be_trans_ready ),
        .tx_i          ( be_tx          ),
        .tx_valid_i    ( be_tx_valid    ),
        .tx_ready_o    ( be_tx_ready    ),
        .rx_o          ( be_rx          ),
        .rx_valid_o    ( be_rx_valid    ),
        .rx_ready_i    ( be_rx_ready    ),
        .b_error_o     ( b_error        ),
        .b_valid_o     ( b_valid        ),
        .b_ready_i     ( b_ready        )
    );

endmodule

//--- bench/hyper_arb_props.sv
// Bound into hyper_phy_arbiter and reads its internal state; reset is synchronous active high
`timescale 1ns/1ps

module hyper_arb_props (
    input logic                 clk_phy_i,
    input logic                 rst_i,
    input logic                 axi_trans_valid_i,
    input logic                 axi_trans_ready_i,
    input logic                 udma_trans_valid_i,
    input logic                 udma_trans_ready_i,
    input hyper_pkg::hyper_tx_t phy_tx_i,
    input logic                 phy_tx_valid_i,
    input logic                 phy_tx_ready_i,
    input logic                 axi_rx_valid_i,
    input logic                 udma_rx_valid_i,
    input logic                 sel_i,
    input logic                 trans_sent_i,
    input logic                 is_write_i
);

    // Descriptor ready goes to one requesting master at a time
    one_trans_ready: assert property (@(posedge clk_phy_i) disable iff (rst_i)
        !(axi_trans_ready_i && udma_trans_ready_i)
        && (!axi_trans_ready_i || axi_trans_valid_i)
        && (!udma_trans_ready_i || udma_trans_valid_i))
        else $error("trans ready to both masters or to a master that did not request");

    tx_stable: assert property (@(posedge clk_phy_i) disable iff (rst_i)
        (phy_tx_valid_i && !phy_tx_ready_i) |=> (phy_tx_valid_i && $stable(phy_tx_i)))
        else $error("phy_tx changed or dropped while stalled");

    // Read beats go only to the granted master once its read descriptor is out
    axi_rx_granted: assert property (@(posedge clk_phy_i) disable iff (rst_i)
        axi_rx_valid_i |-> (!sel_i && trans_sent_i && !is_write_i))
        else $error("AXI read valid without an AXI read in progress");

    udma_rx_granted: assert property (@(posedge clk_phy_i) disable iff (rst_i)
        udma_rx_valid_i |-> (sel_i && trans_sent_i && !is_write_i))
        else $error("uDMA read valid without a uDMA read in progress");

endmodule

bind hyper_phy_arbiter hyper_arb_props u_props (
    .clk_phy_i          ( clk_phy_i          ),
    .rst_i              ( rst_i              ),
    .axi_trans_valid_i  ( axi_trans_valid_i  ),
    .axi_trans_ready_i  ( axi_trans_ready_o  ),
    .udma_trans_valid_i ( udma_trans_valid_i ),
    .udma_trans_ready_i ( udma_trans_ready_o ),
    .phy_tx_i           ( phy_tx_o           ),
    .phy_tx_valid_i     ( phy_tx_valid_o     ),
    .phy_tx_ready_i     ( phy_tx_ready_i     ),
    .axi_rx_valid_i     ( axi_rx_valid_o     ),
    .udma_rx_valid_i    ( udma_rx_valid_o    ),
    .sel_i              ( sel_q              ),
    .trans_sent_i       ( trans_sent_q       ),
    .is_write_i         ( is_write_q         )
);

//--- bench/hyper_arb_tb.sv
// Master 0 is AXI, master 1 is uDMA; inputs change on the falling edge, sampled 1 ns later
`timescale 1ns/1ps

module hyper_arb_tb;
    import hyper_pkg::*;

    localparam int          NUM_TRANS  = 100;
    // Two masters of NUM_TRANS transactions at about 20 cycles each and doubled
    localparam int          MAX_CYCLES = 2 * (2 * NUM_TRANS) * 20;
    localparam logic [31:0] SEED       = 32'hd767;

    typedef struct packed {
        logic      master;
        hyper_rx_t beat;
    } exp_rx_t;

    logic                  clk_phy_i;
    logic                  rst_i;
    hyper_tf_t [1:0]       trans_d;
    logic [1:0]            trans_v;
    hyper_tx_t [1:0]       tx_d;
    logic [1:0]            tx_v;
    logic [1:0]            rx_rdy;
    logic                  b_rdy;
    logic                  axi_trans_ready;
    logic                  udma_trans_ready;
    logic                  axi_tx_ready;
    logic                  udma_tx_ready;
    hyper_rx_t             axi_rx;
    hyper_rx_t             udma_rx;
    logic                  axi_rx_valid;
    logic                  udma_rx_valid;
    logic                  axi_b_error;
    logic                  axi_b_valid;
    logic [1:0]            trans_rdy;
    logic [1:0]            tx_rdy;
    logic [31:0]           rng_q [3];
    logic [DATA_W-1:0]     model_mem [NUM_CHIPS][CHIP_WORDS];
    exp_rx_t               exp_rx [$];
    logic                  exp_b [$];
    int                    last_acc;
    logic                  other_waiting;
    int                    cycle_cnt;

    assign trans_rdy = {udma_trans_ready, axi_trans_ready};
    assign tx_rdy    = {udma_tx_ready, axi_tx_ready};

    hyper_arb_top u_dut (
        .clk_phy_i          ( clk_phy_i        ),
        .rst_i              ( rst_i            ),
        .axi_trans_i        ( trans_d[0]       ),
        .axi_trans_valid_i  ( trans_v[0]       ),
        .axi_trans_ready_o  ( axi_trans_ready  ),
        .axi_tx_i           ( tx_d[0]          ),
        .axi_tx_valid_i     ( tx_v[0]          ),
        .axi_tx_ready_o     ( axi_tx_ready     ),
        .axi_rx_o           ( axi_rx           ),
        .axi_rx_valid_o     ( axi_rx_valid     ),
        .axi_rx_ready_i     ( rx_rdy[0]        ),
        .axi_b_error_o      ( axi_b_error      ),
        .axi_b_valid_o      ( axi_b_valid      ),
        .axi_b_ready_i      ( b_rdy            ),
        .udma_trans_i       ( trans_d[1]       ),
        .udma_trans_valid_i ( trans_v[1]       ),
        .udma_trans_ready_o ( udma_trans_ready ),
        .udma_tx_i          ( tx_d[1]          ),
        .udma_tx_valid_i    ( tx_v[1]          ),
        .udma_tx_ready_o    ( udma_tx_ready    ),
        .udma_rx_o          ( udma_rx          ),
        .udma_rx_valid_o    ( udma_rx_valid    ),
        .udma_rx_ready_i    ( rx_rdy[1]        )
    );

    always #20 clk_phy_i = ~clk_phy_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Streams 0 and 1 feed the masters and stream 2 the ready stalls
    function automatic logic [31:0] next_rand(input int s);
        rng_q[s] = xorshift32(rng_q[s]);
        return rng_q[s];
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    // Model applies a transaction when its descriptor is accepted
    task automatic record_trans(input int m, input hyper_tf_t tf,
                                input logic [3:0][DATA_W-1:0] wd,
                                input logic [3:0][STRB_W-1:0] ws);
        int      a;
        logic    err;
        exp_rx_t e;
        err = 1'b0;
        for (int k = 0; k <= int'(tf.len); k++) begin
            a = int'(tf.addr) + k;
            if (tf.write) begin
                if (a >= CHIP_WORDS) begin
                    err = 1'b1;
                end else begin
                    for (int b = 0; b < STRB_W; b++) begin
                        if (ws[k][b]) begin
                            model_mem[tf.cs][a][8*b +: 8] = wd[k][8*b +: 8];
                        end
                    end
                end
            end else begin
                e.master     = m[0];
                e.beat.data  = (a >= CHIP_WORDS) ? '0 : model_mem[tf.cs][a];
                e.beat.last  = (k == int'(tf.len));
                e.beat.error = (a >= CHIP_WORDS);
                exp_rx.push_back(e);
            end
        end
        if (tf.write && m == 0) begin
            exp_b.push_back(err);
        end
    endtask

    // A master that was already waiting must win the next grant
    task automatic check_fairness(input int m);
        assert (!(last_acc == m && other_waiting)) else
            report_failure($sformatf("master %0d accepted twice while the other waited", m));
        last_acc      = m;
        other_waiting = trans_v[1-m];
    endtask

    task automatic wait_trans_hs(input int m);
        #1;
        while (!trans_rdy[m]) begin
            @(negedge clk_phy_i);
            #1;
        end
    endtask

    task automatic wait_tx_hs(input int m);
        #1;
        while (!tx_rdy[m]) begin
            @(negedge clk_phy_i);
            #1;
        end
    endtask

    task automatic drive_master(input int m);
        hyper_tf_t              tf;
        logic [3:0][DATA_W-1:0] wd;
        logic [3:0][STRB_W-1:0] ws;
        logic [31:0]            r;
        for (int t = 0; t < NUM_TRANS; t++) begin
            r        = next_rand(m);
            tf.write = r[0];
            tf.cs    = r[1];
            tf.len   = r[3:2];
            // Start past word 15 about one time in four
            tf.addr  = {(r[5:4] == 2'b00), r[9:6]};
            for (int k = 0; k < 4; k++) begin
                r     = next_rand(m);
                wd[k] = r[15:0];
                ws[k] = r[17:16];
            end
            r = next_rand(m);
            repeat (r[2] ? 0 : int'(r[1:0])) @(negedge clk_phy_i);
            trans_d[m] = tf;
            trans_v[m] = 1'b1;
            wait_trans_hs(m);
            check_fairness(m);
            record_trans(m, tf, wd, ws);
            @(negedge clk_phy_i);
            trans_v[m] = 1'b0;
            if (tf.write) begin
                for (int k = 0; k <= int'(tf.len); k++) begin
                    r = next_rand(m);
                    if (r[1:0] == 2'b00) begin
                        @(negedge clk_phy_i);
                    end
                    tx_d[m].data = wd[k];
                    tx_d[m].last = (k == int'(tf.len));
                    tx_d[m].strb = ws[k];
                    tx_v[m]      = 1'b1;
                    wait_tx_hs(m);
                    @(negedge clk_phy_i);
                    tx_v[m] = 1'b0;
                end
            end
        end
    endtask

    task automatic check_rx_beat(input int m, input hyper_rx_t got);
        exp_rx_t e;
        string   name;
        name = (m == 0) ? "axi_rx_o" : "udma_rx_o";
        assert (exp_rx.size() > 0) else
            report_failure($sformatf("read beat on %s with no read outstanding", name));
        e = exp_rx.pop_front();
        assert (e.master == m[0]) else
            report_failure($sformatf("read beat delivered on %s, owner is master %0d",
                                     name, e.master));
        assert (got.data == e.beat.data) else
            report_failure($sformatf("MISMATCH %s.data: got %h expected %h",
                                     name, got.data, e.beat.data));
        assert (got.last == e.beat.last) else
            report_failure($sformatf("MISMATCH %s.last: got %h expected %h",
                                     name, got.last, e.beat.last));
        assert (got.error == e.beat.error) else
            report_failure($sformatf("MISMATCH %s.error: got %h expected %h",
                                     name, got.error, e.beat.error));
    endtask

    task automatic check_b_resp(input logic got);
        logic exp;
        assert (exp_b.size() > 0) else
            report_failure("write response with no AXI write outstanding");
        exp = exp_b.pop_front();
        assert (got == exp) else
            report_failure($sformatf("MISMATCH axi_b_error_o: got %h expected %h", got, exp));
    endtask

    // Random stalls keep ready high about three cycles in four
    always begin
        logic [31:0] r;
        @(negedge clk_phy_i);
        r      = next_rand(2);
        rx_rdy = {r[1:0] != 2'b00, r[3:2] != 2'b00};
        b_rdy  = (r[5:4] != 2'b00);
    end

    always begin
        @(negedge clk_phy_i);
        #1;
        if (!rst_i) begin
            if (axi_rx_valid && rx_rdy[0]) begin
                check_rx_beat(0, axi_rx);
            end
            if (udma_rx_valid && rx_rdy[1]) begin
                check_rx_beat(1, udma_rx);
            end
            if (axi_b_valid && b_rdy) begin
                check_b_resp(axi_b_error);
            end
        end
    end

    always @(posedge clk_phy_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            report_failure($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        clk_phy_i     = 1'b0;
        rst_i         = 1'b1;
        trans_d       = '0;
        trans_v       = '0;
        tx_d          = '0;
        tx_v          = '0;
        rx_rdy        = '0;
        b_rdy         = 1'b0;
        last_acc      = -1;
        other_waiting = 1'b0;
        cycle_cnt     = 0;
        for (int s = 0; s < 3; s++) begin
            rng_q[s] = SEED ^ (32'(s) * 32'h9e37_79b9);
        end
        for (int c = 0; c < NUM_CHIPS; c++) begin
            for (int w = 0; w < CHIP_WORDS; w++) begin
                model_mem[c][w] = '0;
            end
        end
        repeat (2) @(posedge clk_phy_i);
        @(negedge clk_phy_i);
        rst_i = 1'b0;
        fork
            drive_master(0);
            drive_master(1);
        join
        while (exp_rx.size() != 0 || exp_b.size() != 0) begin
            @(negedge clk_phy_i);
        end
        // Quiet window to catch duplicated beats
        repeat (20) @(negedge clk_phy_i);
        $display("Test passed");
        $finish;
    end

endmodule

//--- list.f
hw/hyper_pkg.sv
hw/hyper_stream_fifo.sv
hw/hyper_phy_arbiter.sv
hw/hyper_mem_backend.sv
hw/hyper_arb_top.sv
bench/hyper_arb_props.sv
bench/hyper_arb_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs with Verilator; a failing run ends in $fatal, so the exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module hyper_arb_tb -Mdir obj_dir -f list.f &&
./obj_dir/Vhyper_arb_tb ||
{ echo "simulation did not pass"; exit 1; }
